//--- dcache_top.f
design/cache_pkg.sv
design/sp_sram.sv
design/tag_match.sv
design/line_datapath.sv
design/cache_ctrl.sv
design/dcache_top.sv
verif/dcache_tb.sv

//--- design/cache_ctrl.sv
// cache controller, one request in flight except overlapped load hits
// write-through, no allocate on store miss, no dirty state
// core request fields must stay stable until gnt_o
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int NUM_WAYS = cache_pkg::DEF_NUM_WAYS,
  parameter int NUM_SETS = cache_pkg::DEF_NUM_SETS
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // core side
  input  logic                        req_i,
  input  logic                        we_i,
  input  cache_pkg::addr_t            addr_i,
  input  cache_pkg::word_t            wdata_i,
  input  cache_pkg::word_be_t         be_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic                        busy_o,
  // lookup results
  input  logic [NUM_WAYS-1:0]         hit_way_i,
  input  logic [NUM_WAYS-1:0]         victim_way_i,
  // array control
  output logic                        arr_req_o,
  output logic                        arr_we_o,
  output logic [NUM_WAYS-1:0]         arr_way_o,
  output logic [$clog2(NUM_SETS)-1:0] arr_index_o,
  output logic                        refill_sel_o,
  // memory side
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output cache_pkg::addr_t            mem_addr_o,
  output cache_pkg::word_t            mem_wdata_o,
  output cache_pkg::word_be_t         mem_be_o,
  input  logic                        mem_gnt_i,
  input  logic                        refill_valid_i,
  // saved request for the datapath
  output cache_pkg::addr_t            req_addr_o,
  output cache_pkg::word_t            req_wdata_o,
  output cache_pkg::word_be_t         req_be_o
);

  localparam int INDEX_WIDTH = $clog2(NUM_SETS);
  localparam int OFS         = cache_pkg::BYTE_OFFSET;

  cache_pkg::ctrl_state_e state_q, state_d;

  // saved request
  cache_pkg::addr_t    req_addr_q;
  cache_pkg::word_t    req_wdata_q;
  cache_pkg::word_be_t req_be_q;
  logic                req_we_q;

  logic load_hit;
  logic accept;

  // a load hit frees the arrays in the cycle its data returns
  assign load_hit = (state_q == cache_pkg::LOOKUP) && !req_we_q && (|hit_way_i);
  assign accept   = req_i && ((state_q == cache_pkg::IDLE) || (load_hit && !we_i));

  assign busy_o      = (state_q != cache_pkg::IDLE);
  assign req_addr_o  = req_addr_q;
  assign req_wdata_o = req_wdata_q;
  assign req_be_o    = req_be_q;

  // ----------------------------------------------------------------------
  // memory request fields come from the saved request only
  // ----------------------------------------------------------------------
  assign mem_req_o   = (state_q == cache_pkg::MEM_REQ);
  assign mem_we_o    = req_we_q;
  // reads fetch the whole line
  assign mem_addr_o  = req_we_q ? req_addr_q
                                : {req_addr_q[cache_pkg::ADDR_WIDTH-1:OFS], {OFS{1'b0}}};
  assign mem_wdata_o = req_wdata_q;
  assign mem_be_o    = req_be_q;

  // ----------------------------------------------------------------------
  // next state and array control
  // ----------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    gnt_o        = 1'b0;
    rvalid_o     = 1'b0;
    arr_req_o    = 1'b0;
    arr_we_o     = 1'b0;
    arr_way_o    = '0;
    arr_index_o  = req_addr_q[OFS +: INDEX_WIDTH];
    refill_sel_o = 1'b0;

    case (state_q)
      cache_pkg::LOOKUP: begin
        if (|hit_way_i) begin
          if (!req_we_q) begin
            rvalid_o = 1'b1;
            state_d  = cache_pkg::IDLE;
          end else begin
            state_d = cache_pkg::STORE_WRITE;
          end
        end else begin
          // miss, load or store goes out to memory
          state_d = cache_pkg::MEM_REQ;
        end
      end
      cache_pkg::STORE_WRITE: begin
        // merged line into the hit way, then write through
        arr_req_o = 1'b1;
        arr_we_o  = 1'b1;
        arr_way_o = hit_way_i;
        state_d   = cache_pkg::MEM_REQ;
      end
      cache_pkg::MEM_REQ: begin
        if (mem_gnt_i) begin
          state_d = req_we_q ? cache_pkg::IDLE : cache_pkg::WAIT_REFILL;
        end
      end
      cache_pkg::WAIT_REFILL: begin
        if (refill_valid_i) begin
          // critical word to the core, whole line into the victim
          rvalid_o     = 1'b1;
          refill_sel_o = 1'b1;
          arr_req_o    = 1'b1;
          arr_we_o     = 1'b1;
          arr_way_o    = victim_way_i;
          state_d      = cache_pkg::REFILL_WRITE;
        end
      end
      cache_pkg::REFILL_WRITE: begin
        // turnaround after the fill, victim pointer has moved on
        state_d = cache_pkg::IDLE;
      end
      default: begin
        state_d = cache_pkg::IDLE;
      end
    endcase

    // speculative read of all ways on acceptance
    if (accept) begin
      gnt_o       = 1'b1;
      arr_req_o   = 1'b1;
      arr_way_o   = '1;
      arr_index_o = addr_i[OFS +: INDEX_WIDTH];
      state_d     = cache_pkg::LOOKUP;
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= cache_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q  <= addr_i;
      req_we_q    <= we_i;
      req_wdata_q <= wdata_i;
      req_be_q    <= be_i;
    end
  end

  // memory request held with all fields until granted
  a_mem_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
                                   && $stable(mem_wdata_o) && $stable(mem_be_o)))
    else $error("cache_ctrl: memory request changed before grant");

  a_no_rvalid_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == cache_pkg::IDLE) |-> !rvalid_o)
    else $error("cache_ctrl: rvalid in IDLE");

endmodule

//--- design/cache_pkg.sv
// shared widths and types for the data cache
// line width is fixed at two 64-bit words; tag and index widths are
// derived in each module from its NUM_SETS parameter
package cache_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int ADDR_WIDTH     = 32;
  localparam int WORD_WIDTH     = 64;
  localparam int LINE_WIDTH     = 128;
  localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;
  // low address bits that pick a byte inside one line
  localparam int BYTE_OFFSET    = $clog2(LINE_WIDTH / 8);

  // default geometry, the top level may override both
  localparam int DEF_NUM_WAYS = 2;
  localparam int DEF_NUM_SETS = 16;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [LINE_WIDTH-1:0]     line_t;
  typedef logic [WORD_WIDTH/8-1:0]   word_be_t;
  typedef logic [LINE_WIDTH/8-1:0]   line_be_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    MEM_REQ,
    WAIT_REFILL,
    REFILL_WRITE
  } ctrl_state_e;

endpackage

//--- design/dcache_top.sv
// set-associative write-through data cache, one core port
// geometry set here and passed down; NUM_SETS must be a power of two
`timescale 1ns/10ps

module dcache_top #(
  parameter int NUM_WAYS = cache_pkg::DEF_NUM_WAYS,
  parameter int NUM_SETS = cache_pkg::DEF_NUM_SETS
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // core side
  input  logic                req_i,
  input  logic                we_i,
  input  cache_pkg::addr_t    addr_i,
  input  cache_pkg::word_t    wdata_i,
  input  cache_pkg::word_be_t be_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output cache_pkg::word_t    rdata_o,
  output logic                busy_o,
  // memory side
  output logic                mem_req_o,
  output logic                mem_we_o,
  output cache_pkg::addr_t    mem_addr_o,
  output cache_pkg::word_t    mem_wdata_o,
  output cache_pkg::word_be_t mem_be_o,
  input  logic                mem_gnt_i,
  input  logic                refill_valid_i,
  input  cache_pkg::line_t    refill_line_i
);

  localparam int INDEX_WIDTH = $clog2(NUM_SETS);

  logic [NUM_WAYS-1:0]             hit_way;
  logic [NUM_WAYS-1:0]             victim_way;
  logic                            arr_req;
  logic                            arr_we;
  logic [NUM_WAYS-1:0]             arr_way;
  logic [INDEX_WIDTH-1:0]          arr_index;
  logic                            refill_sel;
  cache_pkg::addr_t                req_addr;
  cache_pkg::word_t                req_wdata;
  cache_pkg::word_be_t             req_be;
  cache_pkg::line_t [NUM_WAYS-1:0] line_rdata;
  cache_pkg::line_t                wline;

  cache_ctrl #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .busy_o         (busy_o),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .arr_req_o      (arr_req),
    .arr_we_o       (arr_we),
    .arr_way_o      (arr_way),
    .arr_index_o    (arr_index),
    .refill_sel_o   (refill_sel),
    .mem_req_o      (mem_req_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_be_o       (mem_be_o),
    .mem_gnt_i      (mem_gnt_i),
    .refill_valid_i (refill_valid_i),
    .req_addr_o     (req_addr),
    .req_wdata_o    (req_wdata),
    .req_be_o       (req_be)
  );

  tag_match #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_tag (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .arr_req_i    (arr_req),
    .arr_we_i     (arr_we),
    .arr_way_i    (arr_way),
    .arr_index_i  (arr_index),
    .req_addr_i   (req_addr),
    .refill_sel_i (refill_sel),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  // byte enables are already folded into wline by the merge
  line_datapath #(
    .NUM_WAYS (NUM_WAYS)
  ) u_dp (
    .line_rdata_i  (line_rdata),
    .hit_way_i     (hit_way),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .req_be_i      (req_be),
    .refill_sel_i  (refill_sel),
    .refill_line_i (refill_line_i),
    .rdata_o       (rdata_o),
    .wline_o       (wline),
    .wbe_o         ()
  );

  // ----------------------------------------------------------------------
  // data arrays, one per way
  // ----------------------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_data
    sp_sram #(
      .DEPTH   (NUM_SETS),
      .entry_t (cache_pkg::line_t)
    ) u_line_sram (
      .clk_i   (clk_i),
      .req_i   (arr_req & arr_way[w]),
      .we_i    (arr_we),
      .addr_i  (arr_index),
      .wdata_i (wline),
      .rdata_o (line_rdata[w])
    );
  end

endmodule

//--- design/line_datapath.sv
// word select and write-line merge for the data arrays
// the merge keeps unselected bytes from the hit way's last read line,
// so a store must follow its own lookup with no read in between
`timescale 1ns/10ps

module line_datapath #(
  parameter int NUM_WAYS = cache_pkg::DEF_NUM_WAYS
) (
  input  cache_pkg::line_t [NUM_WAYS-1:0] line_rdata_i,
  input  logic [NUM_WAYS-1:0]             hit_way_i,
  input  cache_pkg::addr_t                req_addr_i,
  input  cache_pkg::word_t                req_wdata_i,
  input  cache_pkg::word_be_t             req_be_i,
  input  logic                            refill_sel_i,
  input  cache_pkg::line_t                refill_line_i,
  output cache_pkg::word_t                rdata_o,
  output cache_pkg::line_t                wline_o,
  output cache_pkg::line_be_t             wbe_o
);

  localparam int WORD_BYTES     = cache_pkg::WORD_WIDTH / 8;
  localparam int WORD_BYTE_BITS = $clog2(WORD_BYTES);
  localparam int WORD_SEL_BITS  = $clog2(cache_pkg::WORDS_PER_LINE);

  logic [WORD_SEL_BITS-1:0] word_idx;
  cache_pkg::line_t         hit_line;
  cache_pkg::line_t         src_line;
  cache_pkg::line_t         new_line;

  // word offset inside the line
  assign word_idx = req_addr_i[cache_pkg::BYTE_OFFSET-1:WORD_BYTE_BITS];

  // or-mux over the one-hot hit vector
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_way_i[w]) begin
        hit_line = hit_line | line_rdata_i[w];
      end
    end
  end

  // on a refill the critical word comes straight from memory
  assign src_line = refill_sel_i ? refill_line_i : hit_line;
  assign rdata_o  = src_line[word_idx*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH];

  // ----------------------------------------------------------------------
  // write line and byte enables
  // ----------------------------------------------------------------------
  always_comb begin
    new_line = '0;
    wbe_o    = '0;
    if (refill_sel_i) begin
      // full line fill
      new_line = refill_line_i;
      wbe_o    = '1;
    end else begin
      // store word lands at its offset
      new_line[word_idx*cache_pkg::WORD_WIDTH +: cache_pkg::WORD_WIDTH] = req_wdata_i;
      wbe_o[word_idx*WORD_BYTES +: WORD_BYTES] = req_be_i;
    end
  end

  // bytewise merge with the stored line
  always_comb begin
    for (int b = 0; b < cache_pkg::LINE_WIDTH / 8; b++) begin
      wline_o[b*8 +: 8] = wbe_o[b] ? new_line[b*8 +: 8] : hit_line[b*8 +: 8];
    end
  end

endmodule

//--- design/sp_sram.sv
// single-port synchronous memory, read data one cycle after req_i
// a write leaves rdata_o holding the last read value
// contents are not reset
`timescale 1ns/10ps

module sp_sram #(
  parameter int  DEPTH   = 16,
  parameter type entry_t = logic [7:0]
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  // storage array
  entry_t mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        // registered read port
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- design/tag_match.sv
// tag arrays, valid bits and round-robin victim pointers
// hit_way_o is only meaningful the cycle after a set read
// victim selection ignores valid bits, pointers start at way 0
`timescale 1ns/10ps

module tag_match #(
  parameter int NUM_WAYS = cache_pkg::DEF_NUM_WAYS,
  parameter int NUM_SETS = cache_pkg::DEF_NUM_SETS
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        arr_req_i,
  input  logic                        arr_we_i,
  input  logic [NUM_WAYS-1:0]         arr_way_i,
  input  logic [$clog2(NUM_SETS)-1:0] arr_index_i,
  input  cache_pkg::addr_t            req_addr_i,
  input  logic                        refill_sel_i,
  output logic [NUM_WAYS-1:0]         hit_way_o,
  output logic [NUM_WAYS-1:0]         victim_way_o
);

  localparam int INDEX_WIDTH = $clog2(NUM_SETS);
  localparam int TAG_WIDTH   = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::BYTE_OFFSET;
  localparam int WAY_BITS    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  tag_t                   tag_rdata [NUM_WAYS];
  tag_t                   req_tag;
  logic [INDEX_WIDTH-1:0] req_index;
  logic [NUM_WAYS-1:0]    valid_q [NUM_SETS];
  logic [WAY_BITS-1:0]    rr_q [NUM_SETS];
  logic                   fill;

  assign req_tag   = req_addr_i[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
  assign req_index = req_addr_i[cache_pkg::BYTE_OFFSET +: INDEX_WIDTH];
  // a refill is the only write that touches tags
  assign fill      = arr_req_i & arr_we_i & refill_sel_i;

  // ----------------------------------------------------------------------
  // tag storage, one array per way
  // ----------------------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    sp_sram #(
      .DEPTH   (NUM_SETS),
      .entry_t (tag_t)
    ) u_tag_sram (
      .clk_i   (clk_i),
      // store hits leave the tag alone
      .req_i   (arr_req_i & arr_way_i[w] & (~arr_we_i | refill_sel_i)),
      .we_i    (arr_we_i),
      .addr_i  (arr_index_i),
      .wdata_i (req_tag),
      .rdata_o (tag_rdata[w])
    );

    // compare against the saved request address
    assign hit_way_o[w] = valid_q[req_index][w] && (tag_rdata[w] == req_tag);
  end

  // ----------------------------------------------------------------------
  // valid bits and victim pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        rr_q[s]    <= '0;
      end
    end else if (fill) begin
      valid_q[arr_index_i] <= valid_q[arr_index_i] | arr_way_i;
      // wrap after the last way
      if (rr_q[arr_index_i] == WAY_BITS'(NUM_WAYS - 1)) begin
        rr_q[arr_index_i] <= '0;
      end else begin
        rr_q[arr_index_i] <= rr_q[arr_index_i] + 1'b1;
      end
    end
  end

  assign victim_way_o = NUM_WAYS'(1) << rr_q[req_index];

  // refills only happen on a miss, so a set never holds one tag twice
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(hit_way_o))
    else $error("tag_match: more than one way hits");

endmodule

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
exit 1

//--- verif/dcache_tb.sv
// directed testbench for dcache_top, 2 ways and 16 sets
// memory model grants after 0..3 cycles and refills 1..4 cycles after grant
// inputs change 1 ns after the rising edge, outputs sampled on the falling edge
`timescale 1ns/10ps

module dcache_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int SEED            = 32'h44dc_9053;

  logic                clk_i;
  logic                rst_n_i;
  logic                req_i;
  logic                we_i;
  cache_pkg::addr_t    addr_i;
  cache_pkg::word_t    wdata_i;
  cache_pkg::word_be_t be_i;
  logic                gnt_o;
  logic                rvalid_o;
  cache_pkg::word_t    rdata_o;
  logic                busy_o;
  logic                mem_req_o;
  logic                mem_we_o;
  cache_pkg::addr_t    mem_addr_o;
  cache_pkg::word_t    mem_wdata_o;
  cache_pkg::word_be_t mem_be_o;
  logic                mem_gnt_i;
  logic                refill_valid_i;
  cache_pkg::line_t    refill_line_i;

  // bookkeeping
  int    cyc;
  int    checks;
  int    errors;
  string cur_test;

  // memory model state, word-aligned keys
  cache_pkg::word_t    mem_model [cache_pkg::addr_t];
  int                  mem_reads;
  int                  mem_writes;
  int                  req_cyc;
  cache_pkg::addr_t    last_rd_addr;
  cache_pkg::addr_t    last_wr_addr;
  cache_pkg::word_t    last_wr_data;
  cache_pkg::word_be_t last_wr_be;

  // load stream used by issue_loads
  cache_pkg::addr_t load_addrs [$];
  cache_pkg::word_t rd_data [$];
  int               gnt_cyc [$];
  int               rv_cyc [$];

  dcache_top #(
    .NUM_WAYS (2),
    .NUM_SETS (16)
  ) dut0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .gnt_o          (gnt_o),
    .rvalid_o       (rvalid_o),
    .rdata_o        (rdata_o),
    .busy_o         (busy_o),
    .mem_req_o      (mem_req_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_be_o       (mem_be_o),
    .mem_gnt_i      (mem_gnt_i),
    .refill_valid_i (refill_valid_i),
    .refill_line_i  (refill_line_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------------------------------------
  // memory model
  // ----------------------------------------------------------------------
  // unwritten words read as a pattern of their full address
  function automatic cache_pkg::word_t model_word(input cache_pkg::addr_t a);
    cache_pkg::addr_t wa;
    wa = {a[31:3], 3'b000};
    if (mem_model.exists(wa)) begin
      return mem_model[wa];
    end
    return {wa ^ 32'h5a3c_96e1, ~wa};
  endfunction

  // bytewise merge of new data over old under byte enables
  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                   input cache_pkg::word_t new_w,
                                                   input cache_pkg::word_be_t be);
    cache_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic serve_request();
    cache_pkg::addr_t    a;
    logic                is_wr;
    cache_pkg::word_t    d;
    cache_pkg::word_be_t be;
    int                  gdly;
    int                  rdly;
    a       = mem_addr_o;
    is_wr   = mem_we_o;
    d       = mem_wdata_o;
    be      = mem_be_o;
    req_cyc = cyc;
    gdly    = $urandom_range(3, 0);
    rdly    = $urandom_range(4, 1);
    repeat (gdly) begin
      @(posedge clk_i);
      #1;
    end
    mem_gnt_i = 1'b1;
    // a write lands at its grant
    if (is_wr) begin
      mem_model[{a[31:3], 3'b000}] = merge_bytes(model_word(a), d, be);
      mem_writes++;
      last_wr_addr = a;
      last_wr_data = d;
      last_wr_be   = be;
    end else begin
      mem_reads++;
      last_rd_addr = a;
    end
    @(posedge clk_i);
    #1;
    mem_gnt_i = 1'b0;
    if (!is_wr) begin
      repeat (rdly - 1) begin
        @(posedge clk_i);
        #1;
      end
      refill_valid_i = 1'b1;
      // lower address word sits in the low half of the line
      refill_line_i  = {model_word(a + 8), model_word(a)};
      @(posedge clk_i);
      #1;
      refill_valid_i = 1'b0;
    end
  endtask

  initial begin
    mem_gnt_i      = 1'b0;
    refill_valid_i = 1'b0;
    refill_line_i  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_n_i && mem_req_o) begin
        serve_request();
      end
    end
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_word(input string what, input cache_pkg::word_t exp,
                            input cache_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input cache_pkg::addr_t exp,
                            input cache_pkg::addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_be(input string what, input cache_pkg::word_be_t exp,
                          input cache_pkg::word_be_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic report_test(input int err_start);
    $display("%s finished, %0d mismatches", cur_test, errors - err_start);
  endtask

  // ----------------------------------------------------------------------
  // core side drivers
  // ----------------------------------------------------------------------
  // loads from load_addrs, next request held ready so hits can overlap
  task automatic issue_loads();
    int issued;
    int done;
    issued = 0;
    done   = 0;
    rd_data.delete();
    gnt_cyc.delete();
    rv_cyc.delete();
    @(posedge clk_i);
    #1;
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = load_addrs[0];
    while (done < load_addrs.size()) begin
      @(negedge clk_i);
      if (rvalid_o) begin
        rv_cyc.push_back(cyc);
        rd_data.push_back(rdata_o);
        done++;
      end
      if (req_i && gnt_o) begin
        gnt_cyc.push_back(cyc);
        issued++;
      end
      @(posedge clk_i);
      #1;
      if (issued < load_addrs.size()) begin
        addr_i = load_addrs[issued];
      end else begin
        req_i = 1'b0;
      end
    end
  endtask

  task automatic load_one(input cache_pkg::addr_t a, output cache_pkg::word_t d);
    load_addrs.delete();
    load_addrs.push_back(a);
    issue_loads();
    d = rd_data[0];
  endtask

  // store, then wait until the write-through has been granted
  task automatic store_word(input cache_pkg::addr_t a, input cache_pkg::word_t d,
                            input cache_pkg::word_be_t be, output int gnt_at);
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = a;
    wdata_i = d;
    be_i    = be;
    @(negedge clk_i);
    while (!gnt_o) begin
      @(negedge clk_i);
    end
    gnt_at = cyc;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
    while (busy_o) begin
      @(negedge clk_i);
    end
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic first_miss();
    int               e0;
    int               rd0;
    cache_pkg::word_t d;
    cur_test = "first_miss";
    e0       = errors;
    rd0      = mem_reads;
    @(negedge clk_i);
    check_count("outputs high after reset", 0,
                int'(busy_o) + int'(gnt_o) + int'(rvalid_o) + int'(mem_req_o));
    load_one(32'h0000_1008, d);
    check_count("memory reads", 1, mem_reads - rd0);
    check_addr("refill address", 32'h0000_1000, last_rd_addr);
    check_word("load data", model_word(32'h0000_1008), d);
    report_test(e0);
  endtask

  task automatic hit_burst();
    int e0;
    int mem0;
    cur_test = "hit_burst";
    e0       = errors;
    mem0     = mem_reads + mem_writes;
    load_addrs.delete();
    load_addrs.push_back(32'h0000_1000);
    load_addrs.push_back(32'h0000_1008);
    load_addrs.push_back(32'h0000_1000);
    load_addrs.push_back(32'h0000_1008);
    issue_loads();
    check_count("memory requests", 0, mem_reads + mem_writes - mem0);
    for (int i = 0; i < load_addrs.size(); i++) begin
      check_word("load data", model_word(load_addrs[i]), rd_data[i]);
      check_count("rvalid cycle", gnt_cyc[i] + 1, rv_cyc[i]);
      // next load granted while this one returns
      if (i + 1 < load_addrs.size()) begin
        check_count("overlapped grant cycle", rv_cyc[i], gnt_cyc[i + 1]);
      end
    end
    report_test(e0);
  endtask

  task automatic store_hit();
    int               e0;
    int               rd0;
    int               wr0;
    int               gnt_at;
    cache_pkg::word_t merged;
    cache_pkg::word_t d;
    cur_test = "store_hit";
    e0       = errors;
    rd0      = mem_reads;
    wr0      = mem_writes;
    merged   = merge_bytes(model_word(32'h0000_1008), 64'h1122_3344_5566_7788, 8'h5a);
    store_word(32'h0000_1008, 64'h1122_3344_5566_7788, 8'h5a, gnt_at);
    check_count("memory writes", 1, mem_writes - wr0);
    check_count("write-through start cycle", gnt_at + 3, req_cyc);
    check_addr("write address", 32'h0000_1008, last_wr_addr);
    check_word("write data", 64'h1122_3344_5566_7788, last_wr_data);
    check_be("write byte enables", 8'h5a, last_wr_be);
    load_one(32'h0000_1008, d);
    check_count("memory reads", 0, mem_reads - rd0);
    check_word("merged load data", merged, d);
    report_test(e0);
  endtask

  task automatic store_miss();
    int               e0;
    int               rd0;
    int               wr0;
    int               gnt_at;
    cache_pkg::word_t merged;
    cache_pkg::word_t d;
    cur_test = "store_miss";
    e0       = errors;
    rd0      = mem_reads;
    wr0      = mem_writes;
    merged   = merge_bytes(model_word(32'h0000_2018), 64'hcafe_f00d_0bad_beef, 8'hf0);
    store_word(32'h0000_2018, 64'hcafe_f00d_0bad_beef, 8'hf0, gnt_at);
    check_count("memory writes", 1, mem_writes - wr0);
    check_count("memory reads after store", 0, mem_reads - rd0);
    check_addr("write address", 32'h0000_2018, last_wr_addr);
    // no allocate, so the load has to miss
    load_one(32'h0000_2018, d);
    check_count("memory reads after load", 1, mem_reads - rd0);
    check_addr("refill address", 32'h0000_2010, last_rd_addr);
    check_word("load data", merged, d);
    report_test(e0);
  endtask

  task automatic replacement();
    int               e0;
    int               rd0;
    cache_pkg::word_t d;
    cur_test = "replacement";
    e0       = errors;
    rd0      = mem_reads;
    // three tags in set 2, the third fill lands on the first line's way
    load_one(32'h0000_3020, d);
    check_word("first line data", model_word(32'h0000_3020), d);
    load_one(32'h0000_4020, d);
    check_word("second line data", model_word(32'h0000_4020), d);
    load_one(32'h0000_5020, d);
    check_word("third line data", model_word(32'h0000_5020), d);
    check_count("fill reads", 3, mem_reads - rd0);
    load_one(32'h0000_4020, d);
    check_count("second line reload reads", 3, mem_reads - rd0);
    check_word("second line reload", model_word(32'h0000_4020), d);
    load_one(32'h0000_3020, d);
    check_count("first line reload reads", 4, mem_reads - rd0);
    check_word("first line reload", model_word(32'h0000_3020), d);
    report_test(e0);
  endtask

  // ----------------------------------------------------------------------
  // watchdog and main sequence
  // ----------------------------------------------------------------------
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST));
    $display("watchdog expired: the tests did not complete within %0d cycles",
             RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
    $display("test failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    cyc        = 0;
    checks     = 0;
    errors     = 0;
    mem_reads  = 0;
    mem_writes = 0;
    req_cyc    = 0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    be_i       = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    first_miss();
    hit_burst();
    store_hit();
    store_miss();
    replacement();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
